//--- include/mci_params.svh
// Bus widths, address map, mailbox depth and user list length
// Also the constant read back from the ID register
`ifndef MCI_PARAMS_SVH
`define MCI_PARAMS_SVH

// Host bus widths
`define MCI_ADDR_WIDTH 32
`define MCI_DATA_WIDTH 32
`define MCI_USER_WIDTH 32
`define MCI_ID_WIDTH 8
`define MCI_STRB_WIDTH (`MCI_DATA_WIDTH / 8)

// Register window, 4 KiB
`define MCI_REG_BASE 32'h0000_0000
`define MCI_REG_SIZE 32'h0000_1000

// Mailbox window, one word per entry
`define MCI_MBOX_BASE 32'h0001_0000
`define MCI_MBOX_DEPTH 256
`define MCI_MBOX_SIZE (`MCI_MBOX_DEPTH * 4)

// Users allowed into the mailbox
`define MCI_NUM_MBOX_USERS 5

`define MCI_ID_VALUE 32'h4D43_4901

`endif

//--- source/mci_pkg.sv
// Vector typedefs for the MCI subordinate
// Host and component request/response structs, subordinate FSM states
`default_nettype none

`include "mci_params.svh"

package mci_pkg;

    typedef logic [`MCI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MCI_DATA_WIDTH-1:0] data_t;
    typedef logic [`MCI_STRB_WIDTH-1:0] strb_t;
    typedef logic [`MCI_USER_WIDTH-1:0] user_t;
    typedef logic [`MCI_ID_WIDTH-1:0]   id_t;

    // Word index inside each target
    typedef logic [2:0]                           reg_idx_t;
    typedef logic [$clog2(`MCI_MBOX_DEPTH)-1:0]   mbox_idx_t;

    // Write: address, data and strobes in one beat
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
        user_t user;
        id_t   id;
    } axi_wr_req_t;

    typedef struct packed {
        addr_t addr;
        user_t user;
        id_t   id;
    } axi_rd_req_t;

    // Shared by the b and r channels
    typedef struct packed {
        data_t data;
        id_t   id;
        logic  err;
    } axi_rsp_t;

    // Internal simplex request
    typedef struct packed {
        addr_t addr;
        logic  write;
        data_t wdata;
        strb_t wstrb;
        user_t user;
    } comp_req_t;

    typedef struct packed {
        data_t rdata;
        logic  hold;
        logic  error;
    } comp_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WRSP,
        RRSP
    } axi_sub_state_t;

endpackage

`default_nettype wire

//--- source/axi_sub.sv
// Host-side subordinate
// Arbitrates single-beat reads against writes, one at a time
// Issues the component request and returns the response with its id
`timescale 1ns/10ps
`default_nettype none

module axi_sub
    import mci_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Write channel, address and data together
    input  logic        wr_valid,
    output logic        wr_ready,
    input  axi_wr_req_t wr_req,
    output logic        b_valid,
    input  logic        b_ready,
    output axi_rsp_t    b_rsp,

    // Read channel
    input  logic        ar_valid,
    output logic        ar_ready,
    input  axi_rd_req_t ar_req,
    output logic        r_valid,
    input  logic        r_ready,
    output axi_rsp_t    r_rsp,

    // Component side
    output logic        comp_dv,
    output comp_req_t   comp_req,
    input  comp_rsp_t   comp_rsp
);

    axi_sub_state_t state_q;
    axi_sub_state_t state_d;
    // Set when the last accepted transfer was a read
    logic           last_rd_q;
    logic           grant_wr;
    logic           grant_rd;
    logic           accept;
    logic           done;
    comp_req_t      req_q;
    axi_rsp_t       rsp_q;

    // Only in IDLE; alternate when both wait
    always_comb begin
        grant_wr = 1'b0;
        grant_rd = 1'b0;
        if (state_q == IDLE) begin
            if (wr_valid && ar_valid) begin
                grant_wr = last_rd_q;
                grant_rd = !last_rd_q;
            end else begin
                grant_wr = wr_valid;
                grant_rd = ar_valid;
            end
        end
    end

    assign wr_ready = grant_wr;
    assign ar_ready = grant_rd;
    assign accept   = grant_wr || grant_rd;

    // Granted request is shown a cycle early
    // Lets the decoder register its user compares before dv
    always_comb begin
        comp_req = req_q;
        if (grant_wr) begin
            comp_req.addr  = wr_req.addr;
            comp_req.write = 1'b1;
            comp_req.wdata = wr_req.data;
            comp_req.wstrb = wr_req.strb;
            comp_req.user  = wr_req.user;
        end else if (grant_rd) begin
            comp_req.addr  = ar_req.addr;
            comp_req.write = 1'b0;
            comp_req.wdata = '0;
            comp_req.wstrb = '0;
            comp_req.user  = ar_req.user;
        end
    end

    assign comp_dv = (state_q == REQ);
    // Target finished this cycle
    assign done    = comp_dv && !comp_rsp.hold;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (accept) state_d = REQ;
            REQ:  if (!comp_rsp.hold) state_d = req_q.write ? WRSP : RRSP;
            WRSP: if (b_ready) state_d = IDLE;
            RRSP: if (r_ready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            last_rd_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                last_rd_q <= grant_rd;
            end
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q    <= comp_req;
            rsp_q.id <= grant_wr ? wr_req.id : ar_req.id;
        end
        if (done) begin
            // Write responses carry no data
            rsp_q.data <= req_q.write ? '0 : comp_rsp.rdata;
            rsp_q.err  <= comp_rsp.error;
        end
    end

    // Held stable until the host takes it
    assign b_valid = (state_q == WRSP);
    assign r_valid = (state_q == RRSP);
    assign b_rsp   = rsp_q;
    assign r_rsp   = rsp_q;

endmodule

`default_nettype wire

//--- source/mci_axi_sub_decode.sv
// Address decoder for the component request
// Register and mailbox windows, mailbox user filter, privilege flags
// Response steering back to the subordinate
`timescale 1ns/10ps
`default_nettype none

`include "mci_params.svh"

module mci_axi_sub_decode
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // From the subordinate
    input  logic      comp_dv,
    input  comp_req_t comp_req,
    output comp_rsp_t comp_rsp,

    // Mailbox access list
    input  user_t [`MCI_NUM_MBOX_USERS-1:0] valid_mbox_users,

    // Strapped privileged users
    input  user_t     strap_soc_config_user,
    input  user_t     strap_mcu_lsu_user,
    input  user_t     strap_mcu_ifu_user,

    // Targets
    output logic      reg_dv,
    input  comp_rsp_t reg_rsp,
    output logic      mbox_dv,
    input  comp_rsp_t mbox_rsp,

    // Privilege flags
    output logic      axi_mci_soc_config_req,
    output logic      axi_mcu_req
);

    logic      reg_hit;
    logic      mbox_hit;
    logic      mbox_user_match;
    logic      mbox_user_ok_q;
    logic      soc_cfg_q;
    logic      mcu_q;
    logic      mbox_sel;

    // Window match on the upper address bits
    assign reg_hit  = (comp_req.addr & ~addr_t'(`MCI_REG_SIZE - 1))
                    == addr_t'(`MCI_REG_BASE);
    assign mbox_hit = (comp_req.addr & ~addr_t'(`MCI_MBOX_SIZE - 1))
                    == addr_t'(`MCI_MBOX_BASE);

    // Any listed user may use the mailbox
    always_comb begin
        mbox_user_match = 1'b0;
        for (int i = 0; i < `MCI_NUM_MBOX_USERS; i++) begin
            if (comp_req.user == valid_mbox_users[i]) begin
                mbox_user_match = 1'b1;
            end
        end
    end

    // User compares registered
    // Request is visible the cycle it is accepted and stable while dv is high
    always_ff @(posedge clk) begin
        if (rst) begin
            mbox_user_ok_q <= 1'b0;
            soc_cfg_q      <= 1'b0;
            mcu_q          <= 1'b0;
        end else begin
            mbox_user_ok_q <= mbox_user_match;
            soc_cfg_q      <= (comp_req.user == strap_soc_config_user);
            mcu_q          <= (comp_req.user == strap_mcu_lsu_user)
                           || (comp_req.user == strap_mcu_ifu_user);
        end
    end

    // Flags only while a request is active
    assign axi_mci_soc_config_req = comp_dv && soc_cfg_q;
    assign axi_mcu_req            = comp_dv && mcu_q;

    // Filtered mailbox access never reaches the SRAM
    assign mbox_sel = mbox_hit && mbox_user_ok_q;
    assign reg_dv   = comp_dv && reg_hit;
    assign mbox_dv  = comp_dv && mbox_sel;

    always_comb begin
        if (reg_hit) begin
            comp_rsp = reg_rsp;
        end else if (mbox_sel) begin
            comp_rsp = mbox_rsp;
        end else begin
            // Miss or refused access answered at once with an error
            comp_rsp = '{rdata: '0, hold: 1'b0, error: 1'b1};
        end
    end

endmodule

`default_nettype wire

//--- source/mci_reg_block.sv
// Register target
// Read-only ID, privileged config register, strobed scratch registers
`timescale 1ns/10ps
`default_nettype none

`include "mci_params.svh"

module mci_reg_block
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dv,
    input  comp_req_t req,
    input  logic      priv,
    output comp_rsp_t rsp
);

    reg_idx_t idx;
    data_t    config_q;
    data_t    scratch_q [2:7];
    data_t    rdata;
    logic     id_wr;
    logic     cfg_denied;

    // Word select, rest of the window aliases
    assign idx = req.addr[2 +: $bits(reg_idx_t)];

    // ID is read-only, config needs the soc-config user
    assign id_wr      = req.write && (idx == reg_idx_t'(0));
    assign cfg_denied = req.write && (idx == reg_idx_t'(1)) && !priv;

    always_ff @(posedge clk) begin
        if (rst) begin
            config_q <= '0;
            for (int r = 2; r < 8; r++) begin
                scratch_q[r] <= '0;
            end
        end else if (dv && req.write) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (req.wstrb[b]) begin
                    if (idx == reg_idx_t'(1)) begin
                        if (priv) config_q[8*b +: 8] <= req.wdata[8*b +: 8];
                    end else if (idx >= reg_idx_t'(2)) begin
                        scratch_q[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        case (idx)
            3'd0:    rdata = `MCI_ID_VALUE;
            3'd1:    rdata = config_q;
            default: rdata = scratch_q[idx];
        endcase
    end

    // Single-cycle answer, reads never fail
    assign rsp = '{rdata: rdata, hold: 1'b0, error: id_wr || cfg_denied};

endmodule

`default_nettype wire

//--- source/mci_mbox_sram.sv
// Mailbox memory target
// Byte-strobed writes, registered read with one hold cycle
`timescale 1ns/10ps
`default_nettype none

`include "mci_params.svh"

module mci_mbox_sram
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dv,
    input  comp_req_t req,
    output comp_rsp_t rsp
);

    data_t     mem [`MCI_MBOX_DEPTH];
    data_t     rdata_q;
    mbox_idx_t idx;
    logic      rd_first;
    logic      pending_q;

    assign idx = req.addr[2 +: $bits(mbox_idx_t)];

    // First cycle of a read, data not there yet
    assign rd_first = dv && !req.write && !pending_q;

    always_ff @(posedge clk) begin
        if (dv && req.write) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (req.wstrb[b]) mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
        if (rd_first) begin
            rdata_q <= mem[idx];
        end
    end

    // Read completes the cycle after it is seen
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= rd_first;
        end
    end

    assign rsp = '{rdata: rdata_q, hold: rd_first, error: 1'b0};

endmodule

`default_nettype wire

//--- source/mci_axi_sub_top.sv
// Top level of the MCI subordinate
// Host subordinate, address decoder, register block and mailbox SRAM
`timescale 1ns/10ps
`default_nettype none

`include "mci_params.svh"

module mci_axi_sub_top
    import mci_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Host write channel
    input  logic        wr_valid,
    output logic        wr_ready,
    input  axi_wr_req_t wr_req,
    output logic        b_valid,
    input  logic        b_ready,
    output axi_rsp_t    b_rsp,

    // Host read channel
    input  logic        ar_valid,
    output logic        ar_ready,
    input  axi_rd_req_t ar_req,
    output logic        r_valid,
    input  logic        r_ready,
    output axi_rsp_t    r_rsp,

    // Access control
    input  user_t [`MCI_NUM_MBOX_USERS-1:0] valid_mbox_users,
    input  user_t       strap_soc_config_user,
    input  user_t       strap_mcu_lsu_user,
    input  user_t       strap_mcu_ifu_user,

    output logic        axi_mci_soc_config_req,
    output logic        axi_mcu_req
);

    // Subordinate to decoder
    logic      comp_dv;
    comp_req_t comp_req;
    comp_rsp_t comp_rsp;

    // Decoder to targets
    logic      reg_dv;
    logic      mbox_dv;
    comp_rsp_t reg_rsp;
    comp_rsp_t mbox_rsp;

    // Host channels collapsed into one request stream
    axi_sub u_axi_sub (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_req   (wr_req),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_rsp    (b_rsp),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_req   (ar_req),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_rsp    (r_rsp),
        .comp_dv  (comp_dv),
        .comp_req (comp_req),
        .comp_rsp (comp_rsp)
    );

    mci_axi_sub_decode u_mci_axi_sub_decode (
        .clk                    (clk),
        .rst                    (rst),
        .comp_dv                (comp_dv),
        .comp_req               (comp_req),
        .comp_rsp               (comp_rsp),
        .valid_mbox_users       (valid_mbox_users),
        .strap_soc_config_user  (strap_soc_config_user),
        .strap_mcu_lsu_user     (strap_mcu_lsu_user),
        .strap_mcu_ifu_user     (strap_mcu_ifu_user),
        .reg_dv                 (reg_dv),
        .reg_rsp                (reg_rsp),
        .mbox_dv                (mbox_dv),
        .mbox_rsp               (mbox_rsp),
        .axi_mci_soc_config_req (axi_mci_soc_config_req),
        .axi_mcu_req            (axi_mcu_req)
    );

    // Config writes gated by the soc-config flag
    mci_reg_block u_mci_reg_block (
        .clk  (clk),
        .rst  (rst),
        .dv   (reg_dv),
        .req  (comp_req),
        .priv (axi_mci_soc_config_req),
        .rsp  (reg_rsp)
    );

    mci_mbox_sram u_mci_mbox_sram (
        .clk (clk),
        .rst (rst),
        .dv  (mbox_dv),
        .req (comp_req),
        .rsp (mbox_rsp)
    );

endmodule

`default_nettype wire

//--- bench/mci_axi_sub_tb.sv
// Table-driven testbench for the MCI subordinate top level
// Host driver with read/write pairs and random response back-pressure
// Privilege flag monitor, watchdog, per-row report
`timescale 1ns/10ps
`default_nettype none

`include "mci_params.svh"

module mci_axi_sub_tb
    import mci_pkg::*;
();

    localparam int   CLK_PERIOD = 4;
    localparam logic WR         = 1'b1;
    localparam logic RD         = 1'b0;

    // Requester identities
    localparam user_t USER_HOST = 32'h0000_0100;
    localparam user_t USER_CFG  = 32'h0000_5A01;
    localparam user_t USER_LSU  = 32'h0000_7701;
    localparam user_t USER_IFU  = 32'h0000_7702;
    localparam user_t USER_BAD  = 32'hBAD0_0001;

    typedef struct packed {
        logic  is_wr;
        addr_t addr;
        data_t data;
        strb_t strb;
        user_t user;
        id_t   id;
        data_t exp_data;
        logic  exp_err;
        logic  exp_soc;
        logic  exp_mcu;
        logic  chk_data;
        logic  paired;
    } row_t;

    logic        clk;
    logic        rst;
    logic        wr_valid;
    logic        wr_ready;
    axi_wr_req_t wr_req;
    logic        b_valid;
    logic        b_ready;
    axi_rsp_t    b_rsp;
    logic        ar_valid;
    logic        ar_ready;
    axi_rd_req_t ar_req;
    logic        r_valid;
    logic        r_ready;
    axi_rsp_t    r_rsp;
    user_t [`MCI_NUM_MBOX_USERS-1:0] mbox_users;
    logic        soc_flag;
    logic        mcu_flag;

    row_t        rows [$];
    int          soc_hits    = 0;
    int          mcu_hits    = 0;
    int          row_errors  = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    logic        table_ready = 1'b0;
    // Set when the last row that should have been served was a read
    logic        last_was_read = 1'b0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    mci_axi_sub_top u_mci_axi_sub_top (
        .clk                    (clk),
        .rst                    (rst),
        .wr_valid               (wr_valid),
        .wr_ready               (wr_ready),
        .wr_req                 (wr_req),
        .b_valid                (b_valid),
        .b_ready                (b_ready),
        .b_rsp                  (b_rsp),
        .ar_valid               (ar_valid),
        .ar_ready               (ar_ready),
        .ar_req                 (ar_req),
        .r_valid                (r_valid),
        .r_ready                (r_ready),
        .r_rsp                  (r_rsp),
        .valid_mbox_users       (mbox_users),
        .strap_soc_config_user  (USER_CFG),
        .strap_mcu_lsu_user     (USER_LSU),
        .strap_mcu_ifu_user     (USER_IFU),
        .axi_mci_soc_config_req (soc_flag),
        .axi_mcu_req            (mcu_flag)
    );

    // Flags come from registers and are stable at the falling edge
    always @(negedge clk) begin
        if (soc_flag) soc_hits <= soc_hits + 1;
        if (mcu_flag) mcu_hits <= mcu_hits + 1;
    end

    // Byte-lane write model shared by registers and mailbox
    function automatic data_t strobe_merge(data_t old_word, data_t new_word, strb_t strb);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    // exp_flags is {err, soc-config, mcu}
    task automatic add_row(input logic is_wr, input addr_t addr, input data_t data,
                           input strb_t strb, input user_t user, input data_t exp_data,
                           input logic [2:0] exp_flags, input logic paired);
        row_t row;
        row.is_wr    = is_wr;
        row.addr     = addr;
        row.data     = data;
        row.strb     = strb;
        row.user     = user;
        row.id       = id_t'(8'h10 + rows.size());
        row.exp_data = exp_data;
        row.exp_err  = exp_flags[2];
        row.exp_soc  = exp_flags[1];
        row.exp_mcu  = exp_flags[0];
        // Write data and refused reads carry nothing to compare
        row.chk_data = !is_wr && !exp_flags[2];
        row.paired   = paired;
        rows.push_back(row);
    endtask

    task automatic build_table();
        data_t scratch2;
        data_t scratch7;
        data_t mbox_word1;
        scratch2   = strobe_merge(32'hAABB_CCDD, 32'h1122_3344, 4'b0101);
        scratch7   = strobe_merge(32'h0, 32'hCAFE_F00D, 4'b1100);
        mbox_word1 = strobe_merge(32'h0102_0304, 32'hA0B0_C0D0, 4'b1010);
        // ID register and a refused write
        add_row(RD, 32'h0000_0000, 32'h0, 4'h0, USER_HOST, `MCI_ID_VALUE, 3'b000, 1'b0);
        add_row(WR, 32'h0000_0000, 32'h1234_5678, 4'hF, USER_HOST, 32'h0, 3'b100, 1'b0);
        add_row(RD, 32'h0000_0000, 32'h0, 4'h0, USER_HOST, `MCI_ID_VALUE, 3'b000, 1'b0);
        // Scratch 2 with a second write from the IFU user
        add_row(WR, 32'h0000_0008, 32'hAABB_CCDD, 4'hF, USER_HOST, 32'h0, 3'b000, 1'b0);
        add_row(WR, 32'h0000_0008, 32'h1122_3344, 4'b0101, USER_IFU, 32'h0, 3'b001, 1'b0);
        add_row(RD, 32'h0000_0008, 32'h0, 4'h0, USER_HOST, scratch2, 3'b000, 1'b0);
        // Scratch 7 from its reset value
        add_row(WR, 32'h0000_001C, 32'hCAFE_F00D, 4'b1100, USER_HOST, 32'h0, 3'b000, 1'b0);
        add_row(RD, 32'h0000_001C, 32'h0, 4'h0, USER_HOST, scratch7, 3'b000, 1'b0);
        // Config register written by the strap user only
        add_row(WR, 32'h0000_0004, 32'h0000_00A5, 4'hF, USER_CFG, 32'h0, 3'b010, 1'b0);
        add_row(RD, 32'h0000_0004, 32'h0, 4'h0, USER_CFG, 32'h0000_00A5, 3'b010, 1'b0);
        add_row(WR, 32'h0000_0004, 32'hFFFF_FFFF, 4'hF, USER_HOST, 32'h0, 3'b100, 1'b0);
        add_row(RD, 32'h0000_0004, 32'h0, 4'h0, USER_LSU, 32'h0000_00A5, 3'b001, 1'b0);
        // Mailbox with listed users
        add_row(WR, 32'h0001_0000, 32'hDEAD_BEEF, 4'hF, USER_HOST, 32'h0, 3'b000, 1'b0);
        add_row(WR, 32'h0001_0004, 32'h0102_0304, 4'hF, USER_LSU, 32'h0, 3'b001, 1'b0);
        add_row(WR, 32'h0001_0004, 32'hA0B0_C0D0, 4'b1010, USER_LSU, 32'h0, 3'b001, 1'b0);
        add_row(RD, 32'h0001_0000, 32'h0, 4'h0, USER_HOST, 32'hDEAD_BEEF, 3'b000, 1'b0);
        add_row(RD, 32'h0001_0004, 32'h0, 4'h0, USER_LSU, mbox_word1, 3'b001, 1'b0);
        // Unlisted user refused
        add_row(WR, 32'h0001_0008, 32'h0000_0055, 4'hF, USER_BAD, 32'h0, 3'b100, 1'b0);
        add_row(RD, 32'h0001_0000, 32'h0, 4'h0, USER_BAD, 32'h0, 3'b100, 1'b0);
        // Outside both windows
        add_row(RD, 32'h0002_0000, 32'h0, 4'h0, USER_HOST, 32'h0, 3'b100, 1'b0);
        add_row(WR, 32'h0000_1000, 32'h0000_0077, 4'hF, USER_HOST, 32'h0, 3'b100, 1'b0);
        // Simultaneous pairs with a single read between them to flip the priority
        add_row(RD, 32'h0001_0000, 32'h0, 4'h0, USER_HOST, 32'hDEAD_BEEF, 3'b000, 1'b1);
        add_row(WR, 32'h0000_000C, 32'h0BAD_CAFE, 4'hF, USER_HOST, 32'h0, 3'b000, 1'b1);
        add_row(RD, 32'h0001_0004, 32'h0, 4'h0, USER_HOST, mbox_word1, 3'b000, 1'b0);
        add_row(WR, 32'h0000_0010, 32'h1357_2468, 4'hF, USER_HOST, 32'h0, 3'b000, 1'b1);
        add_row(RD, 32'h0000_000C, 32'h0, 4'h0, USER_HOST, 32'h0BAD_CAFE, 3'b000, 1'b1);
        add_row(RD, 32'h0000_0010, 32'h0, 4'h0, USER_HOST, 32'h1357_2468, 3'b000, 1'b0);
    endtask

    // Called on a falling edge
    task automatic drive_request(input int idx);
        row_t row;
        row = rows[idx];
        if (row.is_wr) begin
            wr_valid = 1'b1;
            wr_req   = '{addr: row.addr, data: row.data, strb: row.strb,
                         user: row.user, id: row.id};
        end else begin
            ar_valid = 1'b1;
            ar_req   = '{addr: row.addr, user: row.user, id: row.id};
        end
    endtask

    // Ready sampled 1 ns before the rising edge that transfers
    task automatic wait_grant(output logic granted_wr);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            #1;
            if (wr_ready || ar_ready) begin
                seen       = 1'b1;
                granted_wr = wr_ready;
            end else begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        if (granted_wr) wr_valid = 1'b0;
        else ar_valid = 1'b0;
    endtask

    task automatic check_rsp(input int idx, input axi_rsp_t got, input string chan);
        row_t row;
        row = rows[idx];
        assert (got.id == row.id) else begin
            $display("MISMATCH t=%0t %s.id got %h exp %h", $time, chan, got.id, row.id);
            row_errors++;
        end
        assert (got.err == row.exp_err) else begin
            $display("MISMATCH t=%0t %s.err got %b exp %b", $time, chan, got.err, row.exp_err);
            row_errors++;
        end
        if (row.chk_data) begin
            assert (got.data == row.exp_data) else begin
                $display("MISMATCH t=%0t %s.data got %h exp %h",
                         $time, chan, got.data, row.exp_data);
                row_errors++;
            end
        end
    endtask

    // Random stall with ready low while the response must not move
    task automatic collect_rsp(input int idx);
        row_t     row;
        axi_rsp_t first;
        axi_rsp_t got;
        string    chan;
        int       stall;
        row  = rows[idx];
        chan = row.is_wr ? "b_rsp" : "r_rsp";
        #1;
        while (!(row.is_wr ? b_valid : r_valid)) begin
            @(negedge clk);
            #1;
        end
        first = row.is_wr ? b_rsp : r_rsp;
        stall = $urandom % 4;
        repeat (stall) begin
            @(negedge clk);
            #1;
            got = row.is_wr ? b_rsp : r_rsp;
            assert (row.is_wr ? b_valid : r_valid) else begin
                $display("Response valid on %s fell before the host took it", chan);
                row_errors++;
            end
            assert (got == first) else begin
                $display("MISMATCH t=%0t %s got %h exp %h", $time, chan, got, first);
                row_errors++;
            end
        end
        @(negedge clk);
        if (row.is_wr) b_ready = 1'b1;
        else r_ready = 1'b1;
        #1;
        got = row.is_wr ? b_rsp : r_rsp;
        check_rsp(idx, got, chan);
        @(negedge clk);
        b_ready = 1'b0;
        r_ready = 1'b0;
    endtask

    task automatic run_single(input int idx);
        logic granted_wr;
        drive_request(idx);
        wait_grant(granted_wr);
        assert (granted_wr == rows[idx].is_wr) else begin
            $display("MISMATCH t=%0t wr_ready got %b exp %b",
                     $time, granted_wr, rows[idx].is_wr);
            row_errors++;
        end
        last_was_read = !rows[idx].is_wr;
        collect_rsp(idx);
    endtask

    // Read and write presented together and the one not served last goes first
    task automatic run_pair(input int idx);
        logic exp_wr_first;
        logic granted_wr;
        int   first_idx;
        int   second_idx;
        exp_wr_first = last_was_read;
        drive_request(idx);
        drive_request(idx + 1);
        wait_grant(granted_wr);
        assert (granted_wr == exp_wr_first) else begin
            $display("MISMATCH t=%0t wr_ready got %b exp %b", $time, granted_wr, exp_wr_first);
            row_errors++;
        end
        // The read is served second when the write goes first
        last_was_read = exp_wr_first;
        first_idx  = (rows[idx].is_wr == granted_wr) ? idx : idx + 1;
        second_idx = (first_idx == idx) ? idx + 1 : idx;
        collect_rsp(first_idx);
        wait_grant(granted_wr);
        collect_rsp(second_idx);
    endtask

    initial begin
        int   i;
        int   span;
        int   soc_start;
        int   mcu_start;
        logic exp_soc;
        logic exp_mcu;
        void'($urandom(32'h78f1_45dc));
        rst        = 1'b1;
        wr_valid   = 1'b0;
        ar_valid   = 1'b0;
        b_ready    = 1'b0;
        r_ready    = 1'b0;
        wr_req     = '0;
        ar_req     = '0;
        mbox_users = {32'h0000_0104, 32'h0000_0103, USER_LSU, 32'h0000_0101, USER_HOST};
        build_table();
        table_ready = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        i = 0;
        while (i < rows.size()) begin
            row_errors = 0;
            soc_start  = soc_hits;
            mcu_start  = mcu_hits;
            span       = rows[i].paired ? 2 : 1;
            if (span == 2) run_pair(i);
            else run_single(i);
            exp_soc = 1'b0;
            exp_mcu = 1'b0;
            for (int k = i; k < i + span; k++) begin
                exp_soc |= rows[k].exp_soc;
                exp_mcu |= rows[k].exp_mcu;
            end
            assert ((soc_hits != soc_start) == exp_soc) else begin
                $display("MISMATCH t=%0t axi_mci_soc_config_req got %b exp %b",
                         $time, soc_hits != soc_start, exp_soc);
                row_errors++;
            end
            assert ((mcu_hits != mcu_start) == exp_mcu) else begin
                $display("MISMATCH t=%0t axi_mcu_req got %b exp %b",
                         $time, mcu_hits != mcu_start, exp_mcu);
                row_errors++;
            end
            // A pair passes or fails as a unit
            for (int k = i; k < i + span; k++) begin
                if (row_errors == 0) pass_count++;
                else fail_count++;
                $display("row %0d %s addr %h id %h: %s", k, rows[k].is_wr ? "write" : "read",
                         rows[k].addr, rows[k].id, (row_errors == 0) ? "pass" : "fail");
            end
            i += span;
        end
        $display("%0d rows passed, %0d rows failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Forty cycles per row is far above the worst stalled row
    initial begin
        wait (table_ready);
        #(rows.size() * 40 * CLK_PERIOD);
        $display("Run timed out before all rows completed");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
source/mci_pkg.sv
source/axi_sub.sv
source/mci_axi_sub_decode.sv
source/mci_reg_block.sv
source/mci_mbox_sram.sv
source/mci_axi_sub_top.sv
bench/mci_axi_sub_tb.sv
